// ==== alu_pkg.sv ====
package alu_pkg;

	// op codes seen at the alu_top op_i port
	typedef enum logic [3:0] {
		OP_ADD     = 4'd0,   // a + b
		OP_SUB     = 4'd1,   // a - b
		OP_SLT     = 4'd2,   // signed a < b
		OP_SLTU    = 4'd3,   // unsigned a < b
		OP_AND     = 4'd4,
		OP_OR      = 4'd5,
		OP_XOR     = 4'd6,
		OP_NOT     = 4'd7,   // ~b, a ignored
		OP_MUL     = 4'd8,   // low word of a * b
		OP_MULH    = 4'd9,   // high word, signed
		OP_MULHU   = 4'd10,  // high word, unsigned
		OP_SHL_U   = 4'd11,  // logical shift, negative b goes right
		OP_SHL_S   = 4'd12,  // arithmetic shift, negative b goes right
		OP_POW     = 4'd13,  // 1 << b
		OP_POW_SHL = 4'd14   // 1 << b, or a >>> -b when b < 0
	} alu_op_e;

	// which lane the output mux takes
	typedef enum logic [1:0] {
		LANE_ADD = 2'd0,
		LANE_LOG = 2'd1,
		LANE_MUL = 2'd2
	} alu_lane_e;

	// register depth of alu_multiply
	// the add and logic lanes pad to this
	localparam int MUL_STAGES = 4;

endpackage

// ==== pipe.sv ====
module pipe #(
	parameter int               DEPTH     = 1,   // number of register stages
	parameter int               WIDTH     = 8,   // data width
	parameter logic [WIDTH-1:0] RESET_VAL = '0   // value after reset
) (
	input  logic             clk_i,
	input  logic             arst_n_i,
	input  logic [WIDTH-1:0] data_i,
	output logic [WIDTH-1:0] data_o
);

	generate
		if (DEPTH == 0) begin : g_wire
			// no stages, straight through
			assign data_o = data_i;
		end else begin : g_regs
			logic [WIDTH-1:0] stage_r [DEPTH];  // stage 0 is nearest the input

			always_ff @(posedge clk_i or negedge arst_n_i) begin
				if (!arst_n_i) begin
					for (int i = 0; i < DEPTH; i++) begin
						stage_r[i] <= RESET_VAL;
					end
				end else begin
					stage_r[0] <= data_i;
					for (int i = 1; i < DEPTH; i++) begin
						stage_r[i] <= stage_r[i-1];  // shift along
					end
				end
			end

			assign data_o = stage_r[DEPTH-1];
		end
	endgenerate

endmodule

// ==== alu_multiply.sv ====
module alu_multiply #(
	parameter int DATA_W = 33  // operand width, already sign extended by parent
) (
	input  logic                  clk_i,
	input  logic                  arst_n_i,
	input  logic [DATA_W-1:0]     a_i,       // signed operand
	input  logic [DATA_W-1:0]     b_i,       // signed operand
	output logic [2*DATA_W-1:0]   result_o   // signed product
);

	localparam int LO_W      = DATA_W / 2;              // low half, unsigned
	localparam int HI_W      = DATA_W - LO_W;           // high half, signed
	localparam int P_W       = 2 * DATA_W;              // product width
	localparam int MID_W     = LO_W + HI_W + 2;         // cross product sum
	localparam int OUT_DEPTH = alu_pkg::MUL_STAGES - 3; // stages left after the sum

	// stage 1: operand halves
	logic signed [HI_W-1:0]      a_hi_r, b_hi_r;
	logic signed [LO_W:0]        a_lo_r, b_lo_r;  // zero msb keeps them positive
	// stage 2: partial products
	logic signed [2*LO_W+1:0]    pp_ll_r;
	logic signed [LO_W+HI_W:0]   pp_lh_r, pp_hl_r;
	logic signed [2*HI_W-1:0]    pp_hh_r;
	// stage 3: partial sums
	logic signed [MID_W-1:0]     mid_r;
	logic signed [P_W-1:0]       outer_r;
	// stage 4 input
	logic signed [P_W-1:0]       prod;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			a_hi_r  <= '0;
			b_hi_r  <= '0;
			a_lo_r  <= '0;
			b_lo_r  <= '0;
			pp_ll_r <= '0;
			pp_lh_r <= '0;
			pp_hl_r <= '0;
			pp_hh_r <= '0;
			mid_r   <= '0;
			outer_r <= '0;
		end else begin
			// split
			a_hi_r  <= a_i[DATA_W-1:LO_W];
			b_hi_r  <= b_i[DATA_W-1:LO_W];
			a_lo_r  <= {1'b0, a_i[LO_W-1:0]};
			b_lo_r  <= {1'b0, b_i[LO_W-1:0]};
			// four products, each sized to hold its full value
			pp_ll_r <= a_lo_r * b_lo_r;
			pp_lh_r <= a_lo_r * b_hi_r;
			pp_hl_r <= a_hi_r * b_lo_r;
			pp_hh_r <= a_hi_r * b_hi_r;
			// cross terms share a weight
			mid_r   <= pp_lh_r + pp_hl_r;
			// ll is below 2^(2*LO_W), so hh and ll just butt together
			outer_r <= {pp_hh_r, pp_ll_r[2*LO_W-1:0]};
		end
	end

	// cross terms sit LO_W bits up
	assign prod = outer_r + (P_W'(mid_r) <<< LO_W);

	// final sum register
	pipe #(
		.DEPTH     (OUT_DEPTH),
		.WIDTH     (P_W),
		.RESET_VAL ('0)
	) u_sum_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   (prod),
		.data_o   (result_o)
	);

endmodule

// ==== alu_mult_shift.sv ====
module alu_mult_shift #(
	parameter int REGS_IN  = 1,   // in register depth
	parameter int REGS_OUT = 1,   // out register depth
	parameter int DATA_W   = 32
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              sgn_i,     // 1=signed
	input  logic              ext_i,     // 1=high word of product
	input  logic              shl_i,     // 1=shift
	input  logic              pow_i,     // 1=power of two
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	output logic [DATA_W-1:0] result_o
);

	localparam int SH_SEL_W = $clog2(DATA_W);
	localparam int ZSX_W    = DATA_W + 1;     // one extra bit for sign or zero
	localparam int DBL_W    = 2 * ZSX_W;      // multiplier output

	logic [DATA_W-1:0] a, b;            // after in regs
	logic              sgn, ext, shl, pow;
	logic              b_neg;
	logic [DATA_W-1:0] b_pow;
	logic [ZSX_W-1:0]  a_x, b_x;        // extended operands
	logic [ZSX_W-1:0]  a_mux, b_mux;
	logic              ext_mux, ext_mux_r;
	logic [DBL_W-1:0]  res_dbl;
	logic [DATA_W-1:0] result;

	pipe #(
		.DEPTH     (REGS_IN),
		.WIDTH     (2 * DATA_W),
		.RESET_VAL ('0)
	) u_in_data_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   ({b_i, a_i}),
		.data_o   ({b, a})
	);

	pipe #(
		.DEPTH     (REGS_IN),
		.WIDTH     (4),
		.RESET_VAL ('0)
	) u_in_ctrl_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   ({ext_i, pow_i, shl_i, sgn_i}),
		.data_o   ({ext, pow, shl, sgn})
	);

	// sign extend when signed, else zero
	assign a_x   = {sgn & a[DATA_W-1], a};
	assign b_x   = {sgn & b[DATA_W-1], b};
	assign b_pow = DATA_W'(1) << b[SH_SEL_W-1:0];  // low select bits only
	assign b_neg = b[DATA_W-1];

	// a shift is a multiply by 1<<b, a negative distance reads the high word
	always_comb begin
		case ({pow, shl})
			2'b00: begin  // multiply
				a_mux   = a_x;
				b_mux   = b_x;
				ext_mux = ext;
			end
			2'b01: begin  // shift, right when b < 0
				a_mux   = a_x;
				b_mux   = {1'b0, b_pow};
				ext_mux = b_neg;
			end
			2'b10: begin  // pow
				a_mux   = ZSX_W'(1);
				b_mux   = {1'b0, b_pow};
				ext_mux = 1'b0;  // b taken modulo width, never high word
			end
			default: begin  // pow for b >= 0, shift for b < 0
				a_mux   = b_neg ? a_x : ZSX_W'(1);
				b_mux   = {1'b0, b_pow};
				ext_mux = b_neg;
			end
		endcase
	end

	alu_multiply #(
		.DATA_W (ZSX_W)
	) u_multiply (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.a_i      (a_mux),
		.b_i      (b_mux),
		.result_o (res_dbl)
	);

	// word select follows the product down the multiplier
	pipe #(
		.DEPTH     (alu_pkg::MUL_STAGES),
		.WIDTH     (1),
		.RESET_VAL (1'b0)
	) u_ext_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   (ext_mux),
		.data_o   (ext_mux_r)
	);

	// top two product bits are only sign
	assign result = ext_mux_r ? res_dbl[2*DATA_W-1:DATA_W] : res_dbl[DATA_W-1:0];

	pipe #(
		.DEPTH     (REGS_OUT),
		.WIDTH     (DATA_W),
		.RESET_VAL ('0)
	) u_out_regs (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.data_i   (result),
		.data_o   (result_o)
	);

endmodule

// ==== alu_add_sub.sv ====
module alu_add_sub #(
	parameter int REGS_IN  = 1,
	parameter int REGS_OUT = 1,
	parameter int DATA_W   = 32
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              sub_i,    // 1=a-b
	input  logic              slt_i,    // 1=set less than
	input  logic              sgn_i,    // 1=signed compare
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	output logic [DATA_W-1:0] result_o
);

	logic [DATA_W-1:0] a, b;
	logic              sub, slt, sgn;
	logic [DATA_W:0]   a_x, b_x, sum_x;   // one bit wider than the data
	logic [DATA_W-1:0] result, result_r;

	pipe #(
		.DEPTH (REGS_IN), .WIDTH (2 * DATA_W + 3), .RESET_VAL ('0)
	) u_in_regs (
		.clk_i (clk_i), .arst_n_i (arst_n_i),
		.data_i ({sub_i, slt_i, sgn_i, b_i, a_i}),
		.data_o ({sub, slt, sgn, b, a})
	);

	assign a_x   = {sgn & a[DATA_W-1], a};
	assign b_x   = {sgn & b[DATA_W-1], b};
	assign sum_x = (sub | slt) ? a_x - b_x : a_x + b_x;  // compare always subtracts

	// msb of the wide difference is the less-than bit, signed or not
	assign result = slt ? DATA_W'(sum_x[DATA_W]) : sum_x[DATA_W-1:0];

	// pad to the multiplier depth
	pipe #(
		.DEPTH (alu_pkg::MUL_STAGES), .WIDTH (DATA_W), .RESET_VAL ('0)
	) u_mid_regs (
		.clk_i (clk_i), .arst_n_i (arst_n_i),
		.data_i (result), .data_o (result_r)
	);

	pipe #(
		.DEPTH (REGS_OUT), .WIDTH (DATA_W), .RESET_VAL ('0)
	) u_out_regs (
		.clk_i (clk_i), .arst_n_i (arst_n_i),
		.data_i (result_r), .data_o (result_o)
	);

endmodule

// ==== alu_logical.sv ====
module alu_logical #(
	parameter int REGS_IN  = 1,
	parameter int REGS_OUT = 1,
	parameter int DATA_W   = 32
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic [1:0]        fn_i,     // 0=and 1=or 2=xor 3=not b
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	output logic [DATA_W-1:0] result_o
);

	logic [DATA_W-1:0] a, b;
	logic [1:0]        fn;
	logic [DATA_W-1:0] result, result_r;

	pipe #(
		.DEPTH (REGS_IN), .WIDTH (2 * DATA_W + 2), .RESET_VAL ('0)
	) u_in_regs (
		.clk_i (clk_i), .arst_n_i (arst_n_i),
		.data_i ({fn_i, b_i, a_i}), .data_o ({fn, b, a})
	);

	always_comb begin
		case (fn)
			2'd0:    result = a & b;
			2'd1:    result = a | b;
			2'd2:    result = a ^ b;
			default: result = ~b;  // a unused here
		endcase
	end

	pipe #(
		.DEPTH (alu_pkg::MUL_STAGES), .WIDTH (DATA_W), .RESET_VAL ('0)
	) u_mid_regs (
		.clk_i (clk_i), .arst_n_i (arst_n_i),
		.data_i (result), .data_o (result_r)
	);

	pipe #(
		.DEPTH (REGS_OUT), .WIDTH (DATA_W), .RESET_VAL ('0)
	) u_out_regs (
		.clk_i (clk_i), .arst_n_i (arst_n_i),
		.data_i (result_r), .data_o (result_o)
	);

endmodule

// ==== alu_top.sv ====
module alu_top #(
	parameter int REGS_IN  = 1,
	parameter int REGS_OUT = 1,
	parameter int DATA_W   = 32   // 8 or more
) (
	input  logic              clk_i,
	input  logic              arst_n_i,
	input  logic              op_vld_i,   // one cycle strobe
	input  alu_pkg::alu_op_e  op_i,
	input  logic [DATA_W-1:0] a_i,
	input  logic [DATA_W-1:0] b_i,
	output logic              res_vld_o,
	output logic [DATA_W-1:0] result_o
);

	localparam int LAT = REGS_IN + alu_pkg::MUL_STAGES + REGS_OUT;  // every lane

	logic                ms_sgn, ms_ext, ms_shl, ms_pow;  // mult_shift controls
	logic                as_sub, as_slt, as_sgn;          // add_sub controls
	logic [1:0]          lg_fn;
	alu_pkg::alu_lane_e  lane_sel;
	logic [1:0]          lane_r;                          // lane select at output
	logic [DATA_W-1:0]   add_res, log_res, mul_res;

	always_comb begin
		ms_sgn   = 1'b0;
		ms_ext   = 1'b0;
		ms_shl   = 1'b0;
		ms_pow   = 1'b0;
		as_sub   = 1'b0;
		as_slt   = 1'b0;
		as_sgn   = 1'b0;
		lg_fn    = 2'd0;
		lane_sel = alu_pkg::LANE_ADD;
		case (op_i)
			alu_pkg::OP_SUB:  as_sub = 1'b1;
			alu_pkg::OP_SLT: begin
				as_sub = 1'b1;
				as_slt = 1'b1;
				as_sgn = 1'b1;
			end
			alu_pkg::OP_SLTU: begin
				as_sub = 1'b1;
				as_slt = 1'b1;
			end
			alu_pkg::OP_AND: lane_sel = alu_pkg::LANE_LOG;
			alu_pkg::OP_OR: begin
				lane_sel = alu_pkg::LANE_LOG;
				lg_fn    = 2'd1;
			end
			alu_pkg::OP_XOR: begin
				lane_sel = alu_pkg::LANE_LOG;
				lg_fn    = 2'd2;
			end
			alu_pkg::OP_NOT: begin
				lane_sel = alu_pkg::LANE_LOG;
				lg_fn    = 2'd3;
			end
			alu_pkg::OP_MUL:   lane_sel = alu_pkg::LANE_MUL;  // low word, sign moot
			alu_pkg::OP_MULH: begin
				lane_sel = alu_pkg::LANE_MUL;
				ms_sgn   = 1'b1;
				ms_ext   = 1'b1;
			end
			alu_pkg::OP_MULHU: begin
				lane_sel = alu_pkg::LANE_MUL;
				ms_ext   = 1'b1;
			end
			alu_pkg::OP_SHL_U: begin
				lane_sel = alu_pkg::LANE_MUL;
				ms_shl   = 1'b1;
			end
			alu_pkg::OP_SHL_S: begin
				lane_sel = alu_pkg::LANE_MUL;
				ms_shl   = 1'b1;
				ms_sgn   = 1'b1;
			end
			alu_pkg::OP_POW: begin
				lane_sel = alu_pkg::LANE_MUL;
				ms_pow   = 1'b1;
			end
			alu_pkg::OP_POW_SHL: begin
				lane_sel = alu_pkg::LANE_MUL;
				ms_pow   = 1'b1;
				ms_shl   = 1'b1;
				ms_sgn   = 1'b1;  // negative b is an arithmetic right shift
			end
			default: ;  // OP_ADD and unused codes add
		endcase
	end

	alu_add_sub #(.REGS_IN (REGS_IN), .REGS_OUT (REGS_OUT), .DATA_W (DATA_W)) u_add_sub (
		.clk_i (clk_i), .arst_n_i (arst_n_i),
		.sub_i (as_sub), .slt_i (as_slt), .sgn_i (as_sgn),
		.a_i (a_i), .b_i (b_i), .result_o (add_res)
	);

	alu_logical #(.REGS_IN (REGS_IN), .REGS_OUT (REGS_OUT), .DATA_W (DATA_W)) u_logical (
		.clk_i (clk_i), .arst_n_i (arst_n_i), .fn_i (lg_fn),
		.a_i (a_i), .b_i (b_i), .result_o (log_res)
	);

	alu_mult_shift #(.REGS_IN (REGS_IN), .REGS_OUT (REGS_OUT), .DATA_W (DATA_W)) u_mult_shift (
		.clk_i (clk_i), .arst_n_i (arst_n_i),
		.sgn_i (ms_sgn), .ext_i (ms_ext), .shl_i (ms_shl), .pow_i (ms_pow),
		.a_i (a_i), .b_i (b_i), .result_o (mul_res)
	);

	// strobe and lane ride alongside the lanes
	pipe #(.DEPTH (LAT), .WIDTH (1), .RESET_VAL (1'b0)) u_vld_pipe (
		.clk_i (clk_i), .arst_n_i (arst_n_i), .data_i (op_vld_i), .data_o (res_vld_o)
	);

	pipe #(.DEPTH (LAT), .WIDTH (2), .RESET_VAL (2'd0)) u_lane_pipe (
		.clk_i (clk_i), .arst_n_i (arst_n_i), .data_i (lane_sel), .data_o (lane_r)
	);

	always_comb begin
		case (alu_pkg::alu_lane_e'(lane_r))
			alu_pkg::LANE_LOG: result_o = log_res;
			alu_pkg::LANE_MUL: result_o = mul_res;
			default:           result_o = add_res;
		endcase
	end

endmodule

// ==== tb_alu.sv ====
module tb_alu;

	localparam int W          = 32;                            // alu_top default width
	localparam int LAT        = 1 + alu_pkg::MUL_STAGES + 1;   // in regs, multiplier, out regs
	localparam int CLK_PERIOD = 8;
	localparam int N_RAND     = 20;                            // random pairs per directed test
	localparam int N_MIX      = 100;
	// latency, add/sub, logical, multiply, shift/pow, mixed
	localparam int N_OPS      = 1 + (25 + N_RAND) * 4 + N_RAND * 4 + (25 + N_RAND) * 3
		+ 6 * W + N_MIX;
	// reset, latency test idles, mixed gaps, drains
	localparam int N_IDLE     = 2 + 3 * LAT + 10 + N_MIX + 6 * (LAT + 3);
	localparam longint WATCHDOG_T = longint'(N_OPS + N_IDLE + LAT + 20) * CLK_PERIOD;

	localparam logic [W-1:0] EDGE_V [5] = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000,
		32'hffff_ffff};

	logic             clk;
	logic             arst_n_i;
	logic             op_vld_i;
	alu_pkg::alu_op_e op_i;
	logic [W-1:0]     a_i, b_i;
	logic             res_vld_o;
	logic [W-1:0]     result_o;

	logic [W-1:0] exp_q [$];   // expected results, oldest first
	string        desc_q [$];  // matching op text for messages
	integer       seed;
	int           err_cnt, n_checks, n_ops, n_tests;

	alu_top uut (
		.clk_i (clk), .arst_n_i (arst_n_i), .op_vld_i (op_vld_i), .op_i (op_i),
		.a_i (a_i), .b_i (b_i), .res_vld_o (res_vld_o), .result_o (result_o)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// reference model, straight from the op definitions
	function automatic logic [W-1:0] model_result(input alu_pkg::alu_op_e op,
			input logic [W-1:0] a, input logic [W-1:0] b);
		logic [2*W-1:0]        prod_u;
		logic signed [2*W-1:0] prod_s;
		int                    bs;      // b as a signed distance
		int                    d;       // b mod W
		int                    k;       // right shift amount
		logic [W-1:0]          shr_u, shr_s;
		logic [W-1:0]          res;
		prod_u = {{W{1'b0}}, a} * {{W{1'b0}}, b};
		prod_s = $signed({{W{a[W-1]}}, a}) * $signed({{W{b[W-1]}}, b});
		bs = $signed(b);
		d  = ((bs % W) + W) % W;
		k  = (bs < 0) ? -bs : 0;
		if (k >= W) begin  // everything shifted out
			shr_u = '0;
			shr_s = {W{a[W-1]}};
		end else begin
			shr_u = a >> k;
			shr_s = $signed(a) >>> k;
		end
		case (op)
			alu_pkg::OP_ADD:     res = a + b;
			alu_pkg::OP_SUB:     res = a - b;
			alu_pkg::OP_SLT:     res = {{(W-1){1'b0}}, $signed(a) < $signed(b)};
			alu_pkg::OP_SLTU:    res = {{(W-1){1'b0}}, a < b};
			alu_pkg::OP_AND:     res = a & b;
			alu_pkg::OP_OR:      res = a | b;
			alu_pkg::OP_XOR:     res = a ^ b;
			alu_pkg::OP_NOT:     res = ~b;
			alu_pkg::OP_MUL:     res = prod_u[W-1:0];
			alu_pkg::OP_MULH:    res = prod_s[2*W-1:W];
			alu_pkg::OP_MULHU:   res = prod_u[2*W-1:W];
			alu_pkg::OP_SHL_U:   res = (bs >= 0) ? a << d : shr_u;
			alu_pkg::OP_SHL_S:   res = (bs >= 0) ? a << d : shr_s;
			alu_pkg::OP_POW:     res = W'(1) << d;
			alu_pkg::OP_POW_SHL: res = (bs >= 0) ? W'(1) << d : shr_s;
			default:             res = a + b;  // spare code falls into add
		endcase
		return res;
	endfunction

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			$display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
			err_cnt++;
		end
	endtask

	// drive one op on the falling edge, queue what should come back
	task automatic issue_op(input alu_pkg::alu_op_e op, input logic [W-1:0] a,
			input logic [W-1:0] b);
		@(negedge clk);
		op_vld_i = 1'b1;
		op_i     = op;
		a_i      = a;
		b_i      = b;
		exp_q.push_back(model_result(op, a, b));
		desc_q.push_back($sformatf("%s a=%h b=%h", op.name(), a, b));
		n_ops++;
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		op_vld_i = 1'b0;
	endtask

	task automatic drain_results();
		idle_cycle();
		while (exp_q.size() != 0) @(posedge clk);  // pops land on falling edges
	endtask

	task automatic report_test(input string name, input int start_err);
		n_tests++;
		$display("test %s finished with %0d errors", name, err_cnt - start_err);
	endtask

	// compare each result as its strobe shows up
	always @(negedge clk) begin
		if (res_vld_o) begin
			if (exp_q.size() == 0) begin
				$display("result strobe at time %0t with no op outstanding", $time);
				err_cnt++;
			end else begin
				check_val(result_o, exp_q.pop_front(), desc_q.pop_front());
			end
		end
	end

	task automatic test_latency();
		int start_err;
		int cyc;
		int pulses;
		start_err = err_cnt;
		repeat (LAT + 2) begin
			@(negedge clk);
			check_val(res_vld_o, 0, "res_vld_o while idle after reset");
		end
		check_val(result_o, 0, "result_o after reset");
		issue_op(alu_pkg::OP_ADD, 32'h1234_5678, 32'h0000_1111);
		idle_cycle();  // strobe drops after one cycle
		cyc = 1;       // counted from the drive edge, idle_cycle took one
		while (!res_vld_o && cyc < LAT + 4) begin
			@(negedge clk);
			cyc++;
		end
		check_val(cyc, LAT, "cycles from op_vld_i to res_vld_o");
		pulses = res_vld_o ? 1 : 0;
		repeat (LAT + 2) begin
			@(negedge clk);
			if (res_vld_o) pulses++;
		end
		check_val(pulses, 1, "res_vld_o pulses for one op");
		drain_results();
		report_test("latency", start_err);
	endtask

	task automatic test_add_sub();
		int           start_err;
		logic [W-1:0] a, b;
		start_err = err_cnt;
		for (int i = 0; i < 25; i++) begin  // every pair of edge values
			a = EDGE_V[i / 5];
			b = EDGE_V[i % 5];
			issue_op(alu_pkg::OP_ADD, a, b);
			issue_op(alu_pkg::OP_SUB, a, b);
			issue_op(alu_pkg::OP_SLT, a, b);
			issue_op(alu_pkg::OP_SLTU, a, b);
		end
		for (int i = 0; i < N_RAND; i++) begin
			a = $random(seed);
			b = $random(seed);
			issue_op(alu_pkg::OP_ADD, a, b);
			issue_op(alu_pkg::OP_SUB, a, b);
			issue_op(alu_pkg::OP_SLT, a, b);
			issue_op(alu_pkg::OP_SLTU, a, b);
		end
		drain_results();
		report_test("add_sub", start_err);
	endtask

	task automatic test_logical();
		int           start_err;
		logic [W-1:0] a, b;
		start_err = err_cnt;
		for (int i = 0; i < N_RAND; i++) begin
			a = $random(seed);
			b = $random(seed);
			issue_op(alu_pkg::OP_AND, a, b);
			issue_op(alu_pkg::OP_OR, a, b);
			issue_op(alu_pkg::OP_XOR, a, b);
			issue_op(alu_pkg::OP_NOT, a, b);
		end
		drain_results();
		report_test("logical", start_err);
	endtask

	task automatic test_multiply();
		int           start_err;
		logic [W-1:0] a, b;
		start_err = err_cnt;
		for (int i = 0; i < 25 + N_RAND; i++) begin
			a = (i < 25) ? EDGE_V[i / 5] : $random(seed);  // extremes first
			b = (i < 25) ? EDGE_V[i % 5] : $random(seed);
			issue_op(alu_pkg::OP_MUL, a, b);
			issue_op(alu_pkg::OP_MULH, a, b);
			issue_op(alu_pkg::OP_MULHU, a, b);
		end
		drain_results();
		report_test("multiply", start_err);
	endtask

	task automatic test_shift_pow();
		int           start_err;
		logic [W-1:0] a;
		start_err = err_cnt;
		for (int sb = -W; sb < W; sb++) begin
			a = $random(seed);
			issue_op(alu_pkg::OP_SHL_U, a, W'(sb));
			issue_op(alu_pkg::OP_SHL_S, a, W'(sb));
		end
		for (int sb = 0; sb < W; sb++) begin
			issue_op(alu_pkg::OP_POW, $random(seed), W'(sb));  // a is ignored
		end
		for (int sb = -1; sb >= -W; sb--) begin
			issue_op(alu_pkg::OP_POW_SHL, $random(seed), W'(sb));
		end
		drain_results();
		report_test("shift_pow", start_err);
	endtask

	task automatic test_mixed();
		int               start_err;
		alu_pkg::alu_op_e op;
		logic [W-1:0]     a, b;
		start_err = err_cnt;
		for (int i = 0; i < N_MIX; i++) begin
			op = alu_pkg::alu_op_e'(($random(seed) & 32'h7fff_ffff) % 15);
			a  = $random(seed);
			b  = $random(seed);
			if (op >= alu_pkg::OP_SHL_U) b = W'(int'($random(seed) & 63) - W);  // -W..W-1
			issue_op(op, a, b);
			if (($random(seed) & 7) == 0) idle_cycle();  // occasional bubble
		end
		drain_results();
		report_test("mixed", start_err);
	endtask

	initial begin
		#(WATCHDOG_T);
		$display("watchdog timeout at %0t, results still outstanding: %0d", $time, exp_q.size());
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		seed     = 32'h2b5e;
		err_cnt  = 0;
		n_checks = 0;
		n_ops    = 0;
		n_tests  = 0;
		arst_n_i = 1'b0;
		op_vld_i = 1'b0;
		op_i     = alu_pkg::OP_ADD;
		a_i      = '0;
		b_i      = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;
		test_latency();
		test_add_sub();
		test_logical();
		test_multiply();
		test_shift_pow();
		test_mixed();
		repeat (LAT + 2) @(negedge clk);  // stray strobes get flagged by the monitor
		if (exp_q.size() != 0) begin
			$display("%0d expected results never arrived", exp_q.size());
			err_cnt++;
		end
		$display("tests %0d, ops %0d, checks %0d, errors %0d", n_tests, n_ops, n_checks, err_cnt);
		if (err_cnt == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
alu_pkg.sv
pipe.sv
alu_multiply.sv
alu_mult_shift.sv
alu_add_sub.sv
alu_logical.sv
alu_top.sv
tb_alu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module tb_alu \
	-f compile.f \
	-o tb_alu_sim

./obj_dir/tb_alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
